// ==== sources.f ====
soc_periph_pkg.sv
periph_bus_decode.sv
soc_ctrl_regs.sv
gpio_regs.sv
soc_timer.sv
fc_event_map.sv
soc_peripherals.sv
tb_soc_peripherals.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with verilator, run it, judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module tb_soc_peripherals -o tb_soc_peripherals \
  && ./obj_dir/tb_soc_peripherals | tee sim.log \
  || { echo "build or simulation did not run"; exit 1; }
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || exit 1
exit 0

// ==== tb_soc_peripherals.sv ====
// testbench for soc_peripherals: apb driver tasks, register and event model, random checks
`timescale 1ns/1ps

module tb_soc_peripherals
  import soc_periph_pkg::*;
();

  localparam int          CLK_PERIOD    = 100;
  localparam logic [31:0] BOOT_RESET    = 32'h1C00_8080;
  // event lines that carry a source, everything else must stay low
  localparam logic [31:0] EVT_USED      = (32'h1 << 7) | (32'h1 << 16) | (32'h1 << 23) |
                                          (32'h1 << 24) | (32'h1 << 30) | (32'h1 << 31);
  // per-test cycle budgets, summed for the watchdog
  localparam int          TEST_CYCLES   = 400 + 300 + 400 + 500 + 400 + 600 + 400;
  localparam int          MARGIN_CYCLES = 1000;

  logic        clk;
  logic        arst_n;
  logic        slow_clk;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  logic        fetch_en_valid;
  logic        fetch_en;
  logic [31:0] bootaddr;
  logic        fetchen;
  logic [31:0] gpio_in;
  logic [31:0] gpio_out;
  logic [31:0] gpio_oe;
  logic [1:0]  hwpe_evt;
  logic [31:0] fc_events;

  int unsigned errors;
  int unsigned checks;
  int unsigned err_mark;
  int unsigned seed_val;

  // model of the software-visible state
  logic [31:0] m_boot;
  logic        m_fetch;
  logic [31:0] m_dir;
  logic [31:0] m_out;
  logic [31:0] m_inten;
  logic [31:0] m_status;

  soc_peripherals dut_i (
    .clk_i               (clk),
    .arst_n_i            (arst_n),
    .slow_clk_i          (slow_clk),
    .apb_req_i           (apb_req),
    .apb_rsp_o           (apb_rsp),
    .fc_fetch_en_valid_i (fetch_en_valid),
    .fc_fetch_en_i       (fetch_en),
    .fc_bootaddr_o       (bootaddr),
    .fc_fetchen_o        (fetchen),
    .gpio_in_i           (gpio_in),
    .gpio_out_o          (gpio_out),
    .gpio_oe_o           (gpio_oe),
    .fc_hwpe_events_i    (hwpe_evt),
    .fc_events_o         (fc_events)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  // hard stop if some wait never returns
  initial begin
    #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("timeout: tests still running after %0d cycles", TEST_CYCLES + MARGIN_CYCLES);
    $display("Verification failed");
    $finish;
  end

  ////////////////////////////////////////
  // checking and bus helpers
  ////////////////////////////////////////
  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error at %0t ns: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("failure at %0t ns: %s", $time, what);
  endtask

  function automatic logic [31:0] reg_addr(input logic [1:0] slot, input logic [9:0] offset);
    return {18'd0, slot, offset, 2'b00};
  endfunction

  // setup and access phase, response sampled inside the access cycle
  task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
    @(negedge clk);
    apb_req.paddr   = addr;
    apb_req.pwdata  = data;
    apb_req.pwrite  = 1'b1;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    @(negedge clk);
    apb_req.penable = 1'b1;
    #1;
    check("pready", 32'd1, 32'(apb_rsp.pready));
    // only slot 3 is unmapped
    check("pslverr", 32'(addr[13:12] == 2'd3), 32'(apb_rsp.pslverr));
    @(negedge clk);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [31:0] addr, output logic [31:0] data);
    @(negedge clk);
    apb_req.paddr   = addr;
    apb_req.pwrite  = 1'b0;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    @(negedge clk);
    apb_req.penable = 1'b1;
    #1;
    data = apb_rsp.prdata;
    check("pready", 32'd1, 32'(apb_rsp.pready));
    check("pslverr", 32'(addr[13:12] == 2'd3), 32'(apb_rsp.pslverr));
    @(negedge clk);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic read_expect(input logic [31:0] addr, input logic [31:0] exp, input string name);
    logic [31:0] data;
    apb_read(addr, data);
    check(name, exp, data);
  endtask

  // called on a falling edge, holds one slow clock level and counts pulses on one event line
  task automatic drive_slow_clk(input logic level, input int unsigned cycles,
                                input int bit_pos, inout int unsigned pulses);
    slow_clk = level;
    for (int c = 0; c < cycles; c++) begin
      @(negedge clk);
      if (fc_events[bit_pos]) begin
        pulses++;
      end
      check("fc_events_o unused bits", 32'd0, fc_events & ~EVT_USED);
    end
  endtask

  task automatic finish_test(input string name);
    $display("test %-26s %0d errors", name, errors - err_mark);
    err_mark = errors;
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////
  task automatic check_soc_ctrl();
    logic [31:0] val;
    logic        bit_v;
    // reset values
    check("fc_bootaddr_o", BOOT_RESET, bootaddr);
    check("fc_fetchen_o", 32'd0, 32'(fetchen));
    check("gpio_oe_o", 32'd0, gpio_oe);
    check("gpio_out_o", 32'd0, gpio_out);
    check("fc_events_o", 32'd0, fc_events);
    read_expect(reg_addr(2'd0, SOC_CTRL_BOOTADDR), BOOT_RESET, "bootaddr");
    for (int i = 0; i < 6; i++) begin
      m_boot = $urandom();
      apb_write(reg_addr(2'd0, SOC_CTRL_BOOTADDR), m_boot);
      read_expect(reg_addr(2'd0, SOC_CTRL_BOOTADDR), m_boot, "bootaddr");
      check("fc_bootaddr_o", m_boot, bootaddr);
      val = $urandom();
      m_fetch = val[0];
      apb_write(reg_addr(2'd0, SOC_CTRL_FETCHEN), val);
      read_expect(reg_addr(2'd0, SOC_CTRL_FETCHEN), 32'(m_fetch), "fetchen");
      check("fc_fetchen_o", 32'(m_fetch), 32'(fetchen));
    end
    // external override beats a write in the same cycle
    for (int i = 0; i < 4; i++) begin
      bit_v = 1'($urandom());
      fetch_en_valid = 1'b1;
      fetch_en       = bit_v;
      apb_write(reg_addr(2'd0, SOC_CTRL_FETCHEN), {31'd0, ~bit_v});
      check("fc_fetchen_o", 32'(bit_v), 32'(fetchen));
      fetch_en = ~bit_v;
      @(negedge clk);
      check("fc_fetchen_o", {31'd0, ~bit_v}, 32'(fetchen));
      fetch_en_valid = 1'b0;
      m_fetch        = ~bit_v;
      read_expect(reg_addr(2'd0, SOC_CTRL_FETCHEN), 32'(m_fetch), "fetchen");
    end
  endtask

  task automatic probe_bus_decode();
    logic [31:0] addr;
    for (int i = 0; i < 8; i++) begin
      addr = reg_addr(2'd3, 10'($urandom()));
      apb_write(addr, $urandom());
      read_expect(addr, 32'd0, "slot 3 prdata");
    end
    // holes inside mapped slots
    for (int i = 0; i < 4; i++) begin
      addr = reg_addr(2'd0, 10'($urandom_range(1023, 2)));
      apb_write(addr, $urandom());
      read_expect(addr, 32'd0, "soc ctrl hole");
      addr = reg_addr(2'd1, 10'($urandom_range(1023, 5)));
      apb_write(addr, $urandom());
      read_expect(addr, 32'd0, "gpio hole");
      addr = reg_addr(2'd2, 10'($urandom_range(1023, 3)));
      apb_write(addr, $urandom());
      read_expect(addr, 32'd0, "timer hole");
    end
    // nothing above may have landed in a real register
    check("fc_bootaddr_o", m_boot, bootaddr);
    check("fc_fetchen_o", 32'(m_fetch), 32'(fetchen));
    check("gpio_oe_o", m_dir, gpio_oe);
    check("gpio_out_o", m_out, gpio_out);
    read_expect(reg_addr(2'd1, GPIO_INTEN), m_inten, "gpio inten");
    read_expect(reg_addr(2'd2, TIMER_CFG), 32'd0, "timer cfg");
  endtask

  task automatic exercise_gpio_data();
    logic [31:0] val;
    for (int i = 0; i < 6; i++) begin
      m_dir = $urandom();
      apb_write(reg_addr(2'd1, GPIO_DIR), m_dir);
      m_out = $urandom();
      apb_write(reg_addr(2'd1, GPIO_OUT), m_out);
      check("gpio_oe_o", m_dir, gpio_oe);
      check("gpio_out_o", m_out, gpio_out);
      read_expect(reg_addr(2'd1, GPIO_DIR), m_dir, "gpio dir");
      read_expect(reg_addr(2'd1, GPIO_OUT), m_out, "gpio out");
      val = $urandom();
      @(negedge clk);
      gpio_in = val;
      repeat (4) @(negedge clk);
      read_expect(reg_addr(2'd1, GPIO_IN), val, "gpio in");
    end
    // inten is still 0, so no status
    read_expect(reg_addr(2'd1, GPIO_INTSTATUS), 32'd0, "gpio intstatus");
  endtask

  task automatic gpio_irq_sequence();
    logic [31:0] edges;
    logic [31:0] clr;
    for (int i = 0; i < 4; i++) begin
      // falling edges never set status
      @(negedge clk);
      gpio_in = '0;
      repeat (4) @(negedge clk);
      apb_write(reg_addr(2'd1, GPIO_INTSTATUS), '1);
      m_status = '0;
      m_inten  = $urandom();
      apb_write(reg_addr(2'd1, GPIO_INTEN), m_inten);
      edges = $urandom();
      @(negedge clk);
      gpio_in = edges;
      repeat (5) @(negedge clk);
      m_status = edges & m_inten;
      check("fc_events_o[24]", 32'(|m_status), 32'(fc_events[FC_EVT_GPIO]));
      read_expect(reg_addr(2'd1, GPIO_INTSTATUS), m_status, "gpio intstatus");
      // write one to clear a random subset
      clr = $urandom();
      apb_write(reg_addr(2'd1, GPIO_INTSTATUS), clr);
      m_status = m_status & ~clr;
      read_expect(reg_addr(2'd1, GPIO_INTSTATUS), m_status, "gpio intstatus");
      check("fc_events_o[24]", 32'(|m_status), 32'(fc_events[FC_EVT_GPIO]));
    end
    apb_write(reg_addr(2'd1, GPIO_INTSTATUS), '1);
    m_status = '0;
    m_inten  = '0;
    apb_write(reg_addr(2'd1, GPIO_INTEN), m_inten);
    repeat (2) @(negedge clk);
    check("fc_events_o[24]", 32'd0, 32'(fc_events[FC_EVT_GPIO]));
  endtask

  task automatic timer_clock_mode();
    int unsigned cmp;
    int unsigned seen;
    int unsigned cyc;
    int unsigned last;
    logic        exp_pulse;
    for (int r = 0; r < 3; r++) begin
      cmp = $urandom_range(9, 2);
      apb_write(reg_addr(2'd2, TIMER_CFG), 32'd0);
      apb_write(reg_addr(2'd2, TIMER_CMP), cmp);
      apb_write(reg_addr(2'd2, TIMER_COUNT), 32'd0);
      apb_write(reg_addr(2'd2, TIMER_CFG), 32'd1);
      seen = 0;
      cyc  = 0;
      last = 0;
      while (seen < 4 && cyc < 100) begin
        @(negedge clk);
        cyc++;
        // count starts at 0 on enable, match plus one register stage
        exp_pulse = (cyc % (cmp + 1)) == 0;
        check("fc_events_o[7]", 32'(exp_pulse), 32'(fc_events[FC_EVT_TIMER_MTIME]));
        check("fc_events_o[16]", 32'(exp_pulse), 32'(fc_events[FC_EVT_TIMER_LO]));
        if (fc_events[FC_EVT_TIMER_MTIME]) begin
          if (seen > 0) begin
            check("timer period", cmp + 1, cyc - last);
          end
          last = cyc;
          seen++;
        end
      end
      if (seen < 4) begin
        report_failure("timer pulses missing in clock mode");
      end
    end
    apb_write(reg_addr(2'd2, TIMER_CFG), 32'd0);
  endtask

  task automatic timer_ref_mode();
    int unsigned cmp;
    int unsigned pulses;
    cmp    = $urandom_range(3, 1);
    pulses = 0;
    slow_clk = 1'b0;
    apb_write(reg_addr(2'd2, TIMER_CMP), cmp);
    apb_write(reg_addr(2'd2, TIMER_COUNT), 32'd0);
    apb_write(reg_addr(2'd2, TIMER_CFG), 32'd3);
    // three full periods of cmp+1 rising edges each
    for (int r = 0; r < 3 * (cmp + 1); r++) begin
      drive_slow_clk(1'b1, $urandom_range(8, 4), FC_EVT_TIMER_MTIME, pulses);
      drive_slow_clk(1'b0, $urandom_range(8, 4), FC_EVT_TIMER_MTIME, pulses);
    end
    drive_slow_clk(1'b0, 8, FC_EVT_TIMER_MTIME, pulses);
    check("ref mode timer pulses", 32'd3, pulses);
    apb_write(reg_addr(2'd2, TIMER_CFG), 32'd0);
    read_expect(reg_addr(2'd2, TIMER_COUNT), 32'd0, "timer count");
  endtask

  task automatic ref_edge_and_hwpe();
    int unsigned toggles;
    int unsigned pulses;
    logic [1:0]  hwpe_v;
    toggles = $urandom_range(20, 10);
    pulses  = 0;
    @(negedge clk);
    for (int t = 0; t < toggles; t++) begin
      drive_slow_clk(~slow_clk, $urandom_range(6, 3), FC_EVT_REF_EDGE, pulses);
    end
    drive_slow_clk(slow_clk, 6, FC_EVT_REF_EDGE, pulses);
    check("ref edge pulses", toggles, pulses);
    // hwpe lines show up one cycle later
    for (int i = 0; i < 16; i++) begin
      hwpe_v   = 2'($urandom());
      hwpe_evt = hwpe_v;
      @(negedge clk);
      check("fc_events_o[31:30]", 32'(hwpe_v), 32'(fc_events[31:30]));
      check("fc_events_o unused bits", 32'd0, fc_events & ~EVT_USED);
    end
    hwpe_evt = 2'b00;
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////
  initial begin
    seed_val       = $urandom(32'h56b8);
    errors         = 0;
    checks         = 0;
    err_mark       = 0;
    arst_n         = 1'b0;
    slow_clk       = 1'b0;
    apb_req        = '0;
    fetch_en_valid = 1'b0;
    fetch_en       = 1'b0;
    gpio_in        = '0;
    hwpe_evt       = 2'b00;
    m_boot         = BOOT_RESET;
    m_fetch        = 1'b0;
    m_dir          = '0;
    m_out          = '0;
    m_inten        = '0;
    m_status       = '0;
    repeat (5) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    check_soc_ctrl();
    finish_test("reset and soc control");
    probe_bus_decode();
    finish_test("bus decode");
    exercise_gpio_data();
    finish_test("gpio data path");
    gpio_irq_sequence();
    finish_test("gpio interrupt");
    timer_clock_mode();
    finish_test("timer clock mode");
    timer_ref_mode();
    finish_test("timer reference mode");
    ref_edge_and_hwpe();
    finish_test("ref edges and hwpe");
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== soc_peripherals.sv ====
// soc peripheral top: apb decode, soc control, gpio, timer and fc event map
`timescale 1ns/1ps

module soc_peripherals
  import soc_periph_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      slow_clk_i,
  input  apb_req_t                  apb_req_i,
  output apb_rsp_t                  apb_rsp_o,
  input  logic                      fc_fetch_en_valid_i,
  input  logic                      fc_fetch_en_i,
  output logic [APB_DATA_WIDTH-1:0] fc_bootaddr_o,
  output logic                      fc_fetchen_o,
  input  logic [N_GPIO-1:0]         gpio_in_i,
  output logic [N_GPIO-1:0]         gpio_out_o,
  output logic [N_GPIO-1:0]         gpio_oe_o,
  input  logic [1:0]                fc_hwpe_events_i,
  output logic [N_FC_EVENTS-1:0]    fc_events_o
);

  apb_req_t slv_req [N_APB_SLAVES];
  apb_rsp_t slv_rsp [N_APB_SLAVES];
  // interrupt sources into the event map
  logic     gpio_irq;
  logic     timer_irq;
  logic     ref_tick;

  ////////////////////////////////////////
  // apb fabric
  ////////////////////////////////////////
  periph_bus_decode periph_bus_decode_i (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .apb_req_i (apb_req_i),
    .slv_req_o (slv_req),
    .slv_rsp_i (slv_rsp),
    .apb_rsp_o (apb_rsp_o)
  );

  ////////////////////////////////////////
  // register slaves
  ////////////////////////////////////////
  soc_ctrl_regs soc_ctrl_regs_i (
    .clk_i               (clk_i),
    .arst_n_i            (arst_n_i),
    .apb_req_i           (slv_req[APB_SLOT_SOC_CTRL]),
    .apb_rsp_o           (slv_rsp[APB_SLOT_SOC_CTRL]),
    .fc_fetch_en_valid_i (fc_fetch_en_valid_i),
    .fc_fetch_en_i       (fc_fetch_en_i),
    .fc_bootaddr_o       (fc_bootaddr_o),
    .fc_fetchen_o        (fc_fetchen_o)
  );

  gpio_regs gpio_regs_i (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .apb_req_i  (slv_req[APB_SLOT_GPIO]),
    .apb_rsp_o  (slv_rsp[APB_SLOT_GPIO]),
    .gpio_in_i  (gpio_in_i),
    .gpio_out_o (gpio_out_o),
    .gpio_oe_o  (gpio_oe_o),
    .gpio_irq_o (gpio_irq)
  );

  // counts clk_i or synced slow clock rises
  soc_timer soc_timer_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .apb_req_i   (slv_req[APB_SLOT_TIMER]),
    .apb_rsp_o   (slv_rsp[APB_SLOT_TIMER]),
    .ref_tick_i  (ref_tick),
    .timer_irq_o (timer_irq)
  );

  fc_event_map fc_event_map_i (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .slow_clk_i       (slow_clk_i),
    .timer_irq_i      (timer_irq),
    .gpio_irq_i       (gpio_irq),
    .fc_hwpe_events_i (fc_hwpe_events_i),
    .ref_tick_o       (ref_tick),
    .fc_events_o      (fc_events_o)
  );

endmodule

// ==== fc_event_map.sv ====
// slow clock synchronizer and edge detector, registered fc event vector
`timescale 1ns/1ps

module fc_event_map
  import soc_periph_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   slow_clk_i,
  input  logic                   timer_irq_i,
  input  logic                   gpio_irq_i,
  input  logic [1:0]             fc_hwpe_events_i,
  output logic                   ref_tick_o,
  output logic [N_FC_EVENTS-1:0] fc_events_o
);

  logic                   sync_q1;
  logic                   sync_q2;
  logic                   hist_q;
  logic                   ref_rise;
  logic                   ref_fall;
  logic [N_FC_EVENTS-1:0] events_d;
  logic [N_FC_EVENTS-1:0] events_q;

  ////////////////////////////////////////
  // slow clock sampling
  ////////////////////////////////////////
  // slow_clk_i is data here, never a clock
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q1 <= 1'b0;
      sync_q2 <= 1'b0;
      hist_q  <= 1'b0;
    end else begin
      sync_q1 <= slow_clk_i;
      sync_q2 <= sync_q1;
      hist_q  <= sync_q2;
    end
  end

  // one-cycle pulses per synced edge
  assign ref_rise   = sync_q2 & ~hist_q;
  assign ref_fall   = ~sync_q2 & hist_q;
  // timer ref mode counts rises only
  assign ref_tick_o = ref_rise;

  ////////////////////////////////////////
  // event vector
  ////////////////////////////////////////
  always_comb begin
    // unused lines tied low
    events_d                     = '0;
    events_d[FC_EVT_TIMER_MTIME] = timer_irq_i;
    events_d[FC_EVT_TIMER_LO]    = timer_irq_i;
    events_d[FC_EVT_REF_EDGE]    = ref_rise | ref_fall;
    events_d[FC_EVT_GPIO]        = gpio_irq_i;
    events_d[FC_EVT_HWPE0]       = fc_hwpe_events_i[0];
    events_d[FC_EVT_HWPE1]       = fc_hwpe_events_i[1];
  end

  // one flop stage toward the fc
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      events_q <= '0;
    end else begin
      events_q <= events_d;
    end
  end

  assign fc_events_o = events_q;

endmodule

// ==== soc_timer.sv ====
// apb system timer: clock or reference-tick counter, compare with auto-reset, irq pulse
`timescale 1ns/1ps

module soc_timer
  import soc_periph_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  apb_req_t apb_req_i,
  output apb_rsp_t apb_rsp_o,
  input  logic     ref_tick_i,
  output logic     timer_irq_o
);

  apb_addr_u                 addr;
  logic                      wr_en;
  logic                      count_wr;
  logic [1:0]                cfg_q;
  logic [APB_DATA_WIDTH-1:0] count_q;
  logic [APB_DATA_WIDTH-1:0] cmp_q;
  logic                      advance;
  logic                      match;

  assign addr.word = apb_req_i.paddr;
  assign wr_en     = apb_wr_access(apb_req_i);
  assign count_wr  = wr_en && addr.fields.offset == TIMER_COUNT;

  // one step per clock, or per slow clock rise in ref mode
  assign advance = cfg_q[TIMER_CFG_EN_BIT] &
                   (cfg_q[TIMER_CFG_REFCLK_BIT] ? ref_tick_i : 1'b1);
  assign match   = advance && (count_q == cmp_q);

  ////////////////////////////////////////
  // counter
  ////////////////////////////////////////
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cfg_q   <= '0;
      count_q <= '0;
      cmp_q   <= '0;
    end else begin
      if (wr_en && addr.fields.offset == TIMER_CFG) begin
        cfg_q <= {apb_req_i.pwdata[TIMER_CFG_REFCLK_BIT],
                  apb_req_i.pwdata[TIMER_CFG_EN_BIT]};
      end
      if (wr_en && addr.fields.offset == TIMER_CMP) begin
        cmp_q <= apb_req_i.pwdata;
      end
      // software load has priority over counting
      if (count_wr) begin
        count_q <= apb_req_i.pwdata;
      end else if (match) begin
        count_q <= '0;
      end else if (advance) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  // pulse on the matching step, fc_event_map registers it
  assign timer_irq_o = match;

  always_comb begin
    case (addr.fields.offset)
      TIMER_CFG:   apb_rsp_o.prdata = APB_DATA_WIDTH'(cfg_q);
      TIMER_COUNT: apb_rsp_o.prdata = count_q;
      TIMER_CMP:   apb_rsp_o.prdata = cmp_q;
      default:     apb_rsp_o.prdata = '0;
    endcase
  end

  assign apb_rsp_o.pready  = 1'b1;
  assign apb_rsp_o.pslverr = 1'b0;

  a_irq_when_enabled: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    timer_irq_o |-> cfg_q[TIMER_CFG_EN_BIT]
  ) else $error("timer irq while disabled");

endmodule

// ==== gpio_regs.sv ====
// apb gpio: direction and output registers, input synchronizer, rising-edge interrupt status
`timescale 1ns/1ps

module gpio_regs
  import soc_periph_pkg::*;
(
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  apb_req_t          apb_req_i,
  output apb_rsp_t          apb_rsp_o,
  input  logic [N_GPIO-1:0] gpio_in_i,
  output logic [N_GPIO-1:0] gpio_out_o,
  output logic [N_GPIO-1:0] gpio_oe_o,
  output logic              gpio_irq_o
);

  apb_addr_u         addr;
  logic              wr_en;
  logic [N_GPIO-1:0] sync_q1;
  logic [N_GPIO-1:0] sync_q2;
  logic [N_GPIO-1:0] prev_q;
  logic [N_GPIO-1:0] dir_q;
  logic [N_GPIO-1:0] out_q;
  logic [N_GPIO-1:0] inten_q;
  logic [N_GPIO-1:0] status_q;
  logic [N_GPIO-1:0] rise;
  logic [N_GPIO-1:0] status_set;
  logic [N_GPIO-1:0] status_clr;

  assign addr.word = apb_req_i.paddr;
  assign wr_en     = apb_wr_access(apb_req_i);

  ////////////////////////////////////////
  // input sync and edge detect
  ////////////////////////////////////////
  // two flops for metastability, third keeps last level
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
      prev_q  <= '0;
    end else begin
      sync_q1 <= gpio_in_i;
      sync_q2 <= sync_q1;
      prev_q  <= sync_q2;
    end
  end

  assign rise       = sync_q2 & ~prev_q;
  assign status_set = rise & inten_q;
  // write one to clear
  assign status_clr = (wr_en && addr.fields.offset == GPIO_INTSTATUS) ?
                      apb_req_i.pwdata : '0;

  ////////////////////////////////////////
  // config and status registers
  ////////////////////////////////////////
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dir_q    <= '0;
      out_q    <= '0;
      inten_q  <= '0;
      status_q <= '0;
    end else begin
      if (wr_en && addr.fields.offset == GPIO_DIR) begin
        dir_q <= apb_req_i.pwdata;
      end
      if (wr_en && addr.fields.offset == GPIO_OUT) begin
        out_q <= apb_req_i.pwdata;
      end
      if (wr_en && addr.fields.offset == GPIO_INTEN) begin
        inten_q <= apb_req_i.pwdata;
      end
      // a new edge survives a clear in the same cycle
      status_q <= (status_q & ~status_clr) | status_set;
    end
  end

  assign gpio_oe_o  = dir_q;
  assign gpio_out_o = out_q;
  // level irq, stays up until software clears every bit
  assign gpio_irq_o = |status_q;

  // read mux
  always_comb begin
    case (addr.fields.offset)
      GPIO_DIR:       apb_rsp_o.prdata = dir_q;
      GPIO_OUT:       apb_rsp_o.prdata = out_q;
      GPIO_IN:        apb_rsp_o.prdata = sync_q2;
      GPIO_INTEN:     apb_rsp_o.prdata = inten_q;
      GPIO_INTSTATUS: apb_rsp_o.prdata = status_q;
      default:        apb_rsp_o.prdata = '0;
    endcase
  end

  assign apb_rsp_o.pready  = 1'b1;
  assign apb_rsp_o.pslverr = 1'b0;

  // status may only rise on pins that were enabled the cycle before
  a_status_needs_inten: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    1'b1 |=> ((status_q & ~$past(status_q) & ~$past(inten_q)) == '0)
  ) else $error("gpio status set on a disabled pin");

endmodule

// ==== soc_ctrl_regs.sv ====
// apb slave for soc control: fc boot address and fetch enable with external override
`timescale 1ns/1ps

module soc_ctrl_regs
  import soc_periph_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  apb_req_t                  apb_req_i,
  output apb_rsp_t                  apb_rsp_o,
  input  logic                      fc_fetch_en_valid_i,
  input  logic                      fc_fetch_en_i,
  output logic [APB_DATA_WIDTH-1:0] fc_bootaddr_o,
  output logic                      fc_fetchen_o
);

  apb_addr_u                 addr;
  logic                      wr_en;
  logic [APB_DATA_WIDTH-1:0] bootaddr_q;
  logic                      fetchen_q;

  assign addr.word = apb_req_i.paddr;
  assign wr_en     = apb_wr_access(apb_req_i);

  ////////////////////////////////////////
  // control registers
  ////////////////////////////////////////
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bootaddr_q <= BOOT_ADDR_DEFAULT;
      fetchen_q  <= 1'b0;
    end else begin
      if (wr_en && addr.fields.offset == SOC_CTRL_BOOTADDR) begin
        bootaddr_q <= apb_req_i.pwdata;
      end
      // external fetch enable beats software
      if (fc_fetch_en_valid_i) begin
        fetchen_q <= fc_fetch_en_i;
      end else if (wr_en && addr.fields.offset == SOC_CTRL_FETCHEN) begin
        fetchen_q <= apb_req_i.pwdata[0];
      end
    end
  end

  // outputs straight from the flops
  assign fc_bootaddr_o = bootaddr_q;
  assign fc_fetchen_o  = fetchen_q;

  ////////////////////////////////////////
  // read back
  ////////////////////////////////////////
  always_comb begin
    case (addr.fields.offset)
      SOC_CTRL_BOOTADDR: apb_rsp_o.prdata = bootaddr_q;
      SOC_CTRL_FETCHEN:  apb_rsp_o.prdata = APB_DATA_WIDTH'(fetchen_q);
      // holes read as zero
      default:           apb_rsp_o.prdata = '0;
    endcase
  end

  // zero wait states, no errors inside a mapped slot
  assign apb_rsp_o.pready  = 1'b1;
  assign apb_rsp_o.pslverr = 1'b0;

endmodule

// ==== periph_bus_decode.sv ====
// apb slot decoder: per-slave psel, response mux and unmapped-slot error
`timescale 1ns/1ps

module periph_bus_decode
  import soc_periph_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  apb_req_t apb_req_i,
  output apb_req_t slv_req_o [N_APB_SLAVES],
  input  apb_rsp_t slv_rsp_i [N_APB_SLAVES],
  output apb_rsp_t apb_rsp_o
);

  apb_addr_u               addr;
  logic [N_APB_SLAVES-1:0] slot_hit;
  logic [N_APB_SLAVES-1:0] psel_vec;

  // slot field picks the slave
  assign addr.word = apb_req_i.paddr;

  ////////////////////////////////////////
  // request fan-out
  ////////////////////////////////////////
  always_comb begin
    for (int i = 0; i < N_APB_SLAVES; i++) begin
      slot_hit[i] = (addr.fields.slot == 2'(i));
    end
  end

  assign psel_vec = slot_hit & {N_APB_SLAVES{apb_req_i.psel}};

  always_comb begin
    for (int i = 0; i < N_APB_SLAVES; i++) begin
      // every slave sees the whole request
      slv_req_o[i]      = apb_req_i;
      // but only the addressed one gets psel
      slv_req_o[i].psel = psel_vec[i];
    end
  end

  ////////////////////////////////////////
  // response mux
  ////////////////////////////////////////
  always_comb begin
    // slot 3 falls through to here, zero data and error
    apb_rsp_o.prdata  = '0;
    apb_rsp_o.pready  = 1'b1;
    apb_rsp_o.pslverr = 1'b1;
    for (int i = 0; i < N_APB_SLAVES; i++) begin
      if (slot_hit[i]) begin
        apb_rsp_o = slv_rsp_i[i];
      end
    end
  end

  // never two slaves in one transfer
  a_psel_onehot: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) $onehot0(psel_vec)
  ) else $error("more than one apb slave selected");

endmodule

// ==== soc_periph_pkg.sv ====
// widths, apb address map, register offsets, fc event bits, apb types and helpers
package soc_periph_pkg;

  ////////////////////////////////////////
  // bus and vector widths
  ////////////////////////////////////////
  localparam int unsigned APB_ADDR_WIDTH = 32;
  localparam int unsigned APB_DATA_WIDTH = 32;
  localparam int unsigned N_GPIO         = 32;
  localparam int unsigned N_FC_EVENTS    = 32;

  // slot sits in paddr[13:12], slot 3 left unmapped
  localparam int unsigned N_APB_SLAVES      = 3;
  localparam int unsigned APB_SLOT_SOC_CTRL = 0;
  localparam int unsigned APB_SLOT_GPIO     = 1;
  localparam int unsigned APB_SLOT_TIMER    = 2;

  ////////////////////////////////////////
  // register word offsets, paddr[11:2]
  ////////////////////////////////////////
  localparam logic [9:0] SOC_CTRL_BOOTADDR = 10'd0;
  localparam logic [9:0] SOC_CTRL_FETCHEN  = 10'd1;

  localparam logic [9:0] GPIO_DIR       = 10'd0;
  localparam logic [9:0] GPIO_OUT       = 10'd1;
  localparam logic [9:0] GPIO_IN        = 10'd2;
  localparam logic [9:0] GPIO_INTEN     = 10'd3;
  localparam logic [9:0] GPIO_INTSTATUS = 10'd4;

  localparam logic [9:0] TIMER_CFG   = 10'd0;
  localparam logic [9:0] TIMER_COUNT = 10'd1;
  localparam logic [9:0] TIMER_CMP   = 10'd2;

  // fc boots from here unless software moves it
  localparam logic [APB_DATA_WIDTH-1:0] BOOT_ADDR_DEFAULT = 32'h1C00_8080;

  // timer cfg bits
  localparam int unsigned TIMER_CFG_EN_BIT     = 0;
  localparam int unsigned TIMER_CFG_REFCLK_BIT = 1;

  // fc event vector positions
  localparam int unsigned FC_EVT_TIMER_MTIME = 7;
  localparam int unsigned FC_EVT_TIMER_LO    = 16;
  localparam int unsigned FC_EVT_REF_EDGE    = 23;
  localparam int unsigned FC_EVT_GPIO        = 24;
  localparam int unsigned FC_EVT_HWPE0       = 30;
  localparam int unsigned FC_EVT_HWPE1       = 31;

  ////////////////////////////////////////
  // apb request / response bundles
  ////////////////////////////////////////
  typedef struct packed {
    logic [APB_ADDR_WIDTH-1:0] paddr;
    logic [APB_DATA_WIDTH-1:0] pwdata;
    logic                      pwrite;
    logic                      psel;
    logic                      penable;
  } apb_req_t;

  typedef struct packed {
    logic [APB_DATA_WIDTH-1:0] prdata;
    logic                      pready;
    logic                      pslverr;
  } apb_rsp_t;

  // decoded view of one paddr word
  typedef struct packed {
    logic [17:0] unused;
    logic [1:0]  slot;
    logic [9:0]  offset;
    logic [1:0]  byte_off;
  } apb_addr_fields_t;

  typedef union packed {
    logic [APB_ADDR_WIDTH-1:0] word;
    apb_addr_fields_t          fields;
  } apb_addr_u;

  // write strobe, high in the access phase of a write
  function automatic logic apb_wr_access(apb_req_t req);
    return req.psel & req.penable & req.pwrite;
  endfunction

endpackage
